// File: files.f
+incdir+common
common/periph_pkg.sv
src/periph_bus_decoder.sv
irc/irc_core.sv
timer/interval_timer.sv
src/periph_top.sv
dv/tb_clock_gen.sv
dv/periph_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
mkdir -p build
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module periph_tb \
	-Mdir build/obj -o periph_sim \
	&& ./build/obj/periph_sim > build/sim.log 2>&1 \
	|| { cat build/sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat build/sim.log
grep -q "TESTS FAILED" build/sim.log && exit 1 || exit 0

// File: dv/periph_tb.sv
/*
 * testbench top for the peripheral subsystem
 * bus tasks, directed and random stimulus, concurrent checks, timeout
 */

`timescale 1ns/1ps

`include "periph_defs.svh"

module periph_tb import periph_pkg::*; ();

	localparam int MAX_CYCLES = 4000;

	logic        clk;
	logic        reset;
	wb_req_t     bus_req;
	wb_rsp_t     bus_rsp;
	logic [1:0]  ext_irq;
	logic        irq;
	logic        irq_ack;
	int          cycle = 0;
	int          error_count = 0;
	int          last_ack_cycle;
	logic        rd_check;
	logic [31:0] rd_exp;
	logic        irc_on;
	logic        hold_low;
	logic        want_high;
	logic        stb_q;
	logic        stb_first;
	logic        mapped;

	tb_clock_gen i_clock_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	periph_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.ext_irq_i (ext_irq),
		.irq_o     (irq),
		.irq_ack_i (irq_ack)
	);

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= bus_req.stb;
		end
	end

	// first cycle of an access and whether its region has a slave
	assign stb_first = bus_req.stb & ~stb_q;
	assign mapped    = (bus_req.adr[29:22] == `REGION_IRC) ||
		(bus_req.adr[29:22] == `REGION_TIMER);

	// ----------------------------------------------------------------------
	//  checks
	// ----------------------------------------------------------------------

	read_data_ok: assert property (@(posedge clk) disable iff (reset)
		(rd_check && bus_rsp.ack) |-> (bus_rsp.dat == rd_exp))
		else begin
			error_count++;
			$display("mismatch at %0t: read data %h, expected %h", $time, bus_rsp.dat, rd_exp);
		end

	mapped_ack_wait: assert property (@(posedge clk) disable iff (reset)
		(stb_first && mapped) |-> !bus_rsp.ack)
		else begin
			error_count++;
			$display("mismatch at %0t: mapped ack in the stb cycle", $time);
		end

	mapped_ack_next: assert property (@(posedge clk) disable iff (reset)
		(stb_first && mapped) |=> bus_rsp.ack)
		else begin
			error_count++;
			$display("mismatch at %0t: mapped ack missing one cycle after stb", $time);
		end

	unmapped_ack_now: assert property (@(posedge clk) disable iff (reset)
		(stb_first && !mapped) |-> bus_rsp.ack)
		else begin
			error_count++;
			$display("mismatch at %0t: unmapped access without immediate ack", $time);
		end

	irq_off_when_disabled: assert property (@(posedge clk) disable iff (reset)
		!irc_on |-> !irq)
		else begin
			error_count++;
			$display("mismatch at %0t: irq high with irc disabled", $time);
		end

	irq_falls_on_ack: assert property (@(posedge clk) disable iff (reset) irq_ack |=> !irq)
		else begin
			error_count++;
			$display("mismatch at %0t: irq still high after acknowledge", $time);
		end

	irq_held_by_mask: assert property (@(posedge clk) disable iff (reset) hold_low |-> !irq)
		else begin
			error_count++;
			$display("mismatch at %0t: irq high although priority not above mask", $time);
		end

	irq_back_after_mask: assert property (@(posedge clk) disable iff (reset) want_high |-> irq)
		else begin
			error_count++;
			$display("mismatch at %0t: irq low after mask cleared", $time);
		end

	always @(negedge clk) begin
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d", error_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	//  bus tasks
	// ----------------------------------------------------------------------

	function automatic logic [29:0] irc_adr(input irc_reg_e r, input int id);
		return {`REGION_IRC, 16'h0, r, 2'(id)};
	endfunction

	function automatic logic [29:0] tmr_adr(input tmr_reg_e r);
		return {`REGION_TIMER, 20'h0, r};
	endfunction

	task automatic bus_access(input logic [29:0] adr, input logic we, input logic [31:0] wdat,
			input logic chk, input logic [31:0] exp);
		@(posedge clk);
		#1;
		bus_req.adr = adr;
		bus_req.we  = we;
		bus_req.dat = wdat;
		bus_req.sel = 4'hF;
		bus_req.stb = 1'b1;
		rd_check    = chk;
		rd_exp      = exp;
		@(negedge clk);
		while (!bus_rsp.ack) begin
			@(negedge clk);
		end
		last_ack_cycle = cycle;
		@(posedge clk);
		#1;
		bus_req.stb = 1'b0;
		bus_req.we  = 1'b0;
		rd_check    = 1'b0;
	endtask

	task automatic write_reg(input logic [29:0] adr, input logic [31:0] wdat);
		bus_access(adr, 1'b1, wdat, 1'b0, '0);
	endtask

	task automatic read_check(input logic [29:0] adr, input logic [31:0] exp);
		bus_access(adr, 1'b0, '0, 1'b1, exp);
	endtask

	// write random data and read it back through the register width
	task automatic write_read(input logic [29:0] adr, input logic [31:0] width_mask);
		logic [31:0] wdat;
		wdat = $urandom;
		write_reg(adr, wdat);
		read_check(adr, wdat & width_mask);
	endtask

	task automatic wait_to_cycle(input int target);
		if (cycle > target) begin
			error_count++;
			$display("schedule error at %0t: cycle %0d already past %0d", $time, cycle, target);
		end
		while (cycle < target) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_irq();
		while (!irq) begin
			@(negedge clk);
		end
	endtask

	task automatic pulse_ack();
		@(posedge clk);
		#1 irq_ack = 1'b1;
		@(posedge clk);
		#1 irq_ack = 1'b0;
	endtask

	task automatic set_ext(input logic [1:0] lines);
		@(posedge clk);
		#1 ext_irq = lines;
	endtask

	// both external factors high, the higher priority or on a tie the lower id wins
	task automatic arbitrate(input logic [1:0] p1, input logic [1:0] p2);
		logic [1:0] win_id;
		logic [1:0] win_pri;
		win_id  = (p2 > p1) ? 2'd2 : 2'd1;
		win_pri = (p2 > p1) ? p2 : p1;
		write_reg(irc_adr(IRC_FACTOR_PRI, 1), 32'(p1));
		write_reg(irc_adr(IRC_FACTOR_PRI, 2), 32'(p2));
		set_ext(2'b11);
		wait_irq();
		pulse_ack();
		read_check(irc_adr(IRC_REQ_ID, 0), 32'(win_id));
		read_check(irc_adr(IRC_MASK, 0), 32'(win_pri));
		set_ext(2'b00);
		write_reg(irc_adr(IRC_MASK, 0), 32'h0);
	endtask

	// ----------------------------------------------------------------------
	//  stimulus
	// ----------------------------------------------------------------------

	initial begin
		int          seed_init;
		int          cmp;
		int          t0;
		logic [1:0]  pri_lo;
		logic [1:0]  pri_hi;
		logic [7:0]  region;
		bus_req   = '0;
		ext_irq   = 2'b00;
		irq_ack   = 1'b0;
		rd_check  = 1'b0;
		rd_exp    = '0;
		irc_on    = 1'b0;
		hold_low  = 1'b0;
		want_high = 1'b0;
		seed_init = $urandom(32'hc71);
		@(negedge reset);

		// register readback
		irc_on = 1'b1;
		write_read(irc_adr(IRC_ENABLE, 0), 32'h1);
		write_reg(irc_adr(IRC_ENABLE, 0), 32'h0);
		irc_on = 1'b0;
		write_read(irc_adr(IRC_MASK, 0), 32'h3);
		for (int i = 0; i < `IRC_FACTOR_NUM; i++) begin
			write_read(irc_adr(IRC_FACTOR_EN, i), 32'h1);
			write_read(irc_adr(IRC_FACTOR_PRI, i), 32'h3);
		end
		write_read(tmr_adr(TMR_COMPARE), 32'hFFFF_FFFF);
		write_read(tmr_adr(TMR_CTRL), 32'h1);
		write_reg(tmr_adr(TMR_CTRL), 32'h0);
		write_reg(tmr_adr(TMR_STATUS), 32'h1);
		write_reg(irc_adr(IRC_MASK, 0), 32'h0);

		// unmapped regions answer at once with zero
		for (int i = 0; i < 3; i++) begin
			region = 8'($urandom);
			if (region == `REGION_IRC || region == `REGION_TIMER) begin
				region = 8'h00;
			end
			read_check({region, 22'($urandom)}, 32'h0);
			write_reg({region, 22'($urandom)}, $urandom);
		end

		// timer period with factor 0 enabled but the irc off
		write_reg(irc_adr(IRC_FACTOR_EN, 0), 32'h1);
		write_reg(irc_adr(IRC_FACTOR_PRI, 0), 32'h3);
		cmp = 10 + int'($urandom % 22);
		write_reg(tmr_adr(TMR_COMPARE), 32'(cmp));
		write_reg(tmr_adr(TMR_CTRL), 32'h1);
		t0 = last_ack_cycle;
		wait_to_cycle(t0 + cmp - 1);
		read_check(tmr_adr(TMR_STATUS), 32'h0);
		read_check(tmr_adr(TMR_STATUS), 32'h1);
		write_reg(tmr_adr(TMR_STATUS), 32'h1);
		read_check(tmr_adr(TMR_STATUS), 32'h0);
		// read issued on the second expiry edge
		wait_to_cycle(t0 + 2 * cmp + 1);
		read_check(tmr_adr(TMR_STATUS), 32'h1);
		write_reg(tmr_adr(TMR_CTRL), 32'h0);
		write_reg(tmr_adr(TMR_STATUS), 32'h1);
		read_check(tmr_adr(TMR_STATUS), 32'h0);

		// arbitration between the external factors
		write_reg(irc_adr(IRC_FACTOR_EN, 0), 32'h0);
		write_reg(irc_adr(IRC_FACTOR_EN, 1), 32'h1);
		write_reg(irc_adr(IRC_FACTOR_EN, 2), 32'h1);
		irc_on = 1'b1;
		write_reg(irc_adr(IRC_ENABLE, 0), 32'h1);
		// the winning factor alternates and the last trial is a tie
		for (int n = 0; n < 4; n++) begin
			pri_lo = 2'(1 + $urandom % 2);
			pri_hi = 2'(pri_lo + 1 + $urandom % (3 - pri_lo));
			if (n == 3) begin
				arbitrate(pri_hi, pri_hi);
			end else if (n % 2 == 1) begin
				arbitrate(pri_hi, pri_lo);
			end else begin
				arbitrate(pri_lo, pri_hi);
			end
		end

		// masking with factor 1 alone at priority 2
		write_reg(irc_adr(IRC_FACTOR_EN, 2), 32'h0);
		write_reg(irc_adr(IRC_FACTOR_PRI, 1), 32'h2);
		write_reg(irc_adr(IRC_MASK, 0), 32'h2);
		hold_low = 1'b1;
		set_ext(2'b01);
		repeat (4) @(posedge clk);
		#1 hold_low = 1'b0;
		write_reg(irc_adr(IRC_MASK, 0), 32'h0);
		wait_irq();
		pulse_ack();
		read_check(irc_adr(IRC_REQ_ID, 0), 32'h1);
		read_check(irc_adr(IRC_MASK, 0), 32'h2);
		write_reg(irc_adr(IRC_MASK, 0), 32'h0);
		want_high = 1'b1;
		repeat (3) @(posedge clk);
		#1 want_high = 1'b0;
		set_ext(2'b00);
		write_reg(irc_adr(IRC_FACTOR_EN, 1), 32'h0);

		// timer expiry through the irc with irq one cycle after the status
		write_reg(irc_adr(IRC_FACTOR_EN, 0), 32'h1);
		cmp = 10 + int'($urandom % 22);
		write_reg(tmr_adr(TMR_COMPARE), 32'(cmp));
		write_reg(tmr_adr(TMR_CTRL), 32'h1);
		t0 = last_ack_cycle;
		wait_irq();
		assert (cycle == t0 + cmp + 2)
			else begin
				error_count++;
				$display("mismatch at %0t: timer irq in cycle %0d, expected %0d",
					$time, cycle, t0 + cmp + 2);
			end
		pulse_ack();
		read_check(irc_adr(IRC_REQ_ID, 0), 32'h0);
		read_check(irc_adr(IRC_MASK, 0), 32'h3);
		write_reg(tmr_adr(TMR_CTRL), 32'h0);
		write_reg(tmr_adr(TMR_STATUS), 32'h1);
		write_reg(irc_adr(IRC_MASK, 0), 32'h0);
		write_reg(irc_adr(IRC_ENABLE, 0), 32'h0);
		irc_on = 1'b0;

		repeat (2) @(posedge clk);
		$display("checks done, errors: %0d", error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: dv/tb_clock_gen.sv
/*
 * testbench clock and reset source
 */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held for two rising edges
	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_o);
		#1 reset_o = 1'b0;
	end

endmodule

// File: src/periph_top.sv
/*
 * peripheral subsystem top, decoder with irc and interval timer
 */

`timescale 1ns/1ps

`include "periph_defs.svh"

module periph_top import periph_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  wb_req_t    bus_req_i,
	output wb_rsp_t    bus_rsp_o,
	input  logic [1:0] ext_irq_i,
	output logic       irq_o,
	input  logic       irq_ack_i
);

	wb_req_t                    irc_req;
	wb_rsp_t                    irc_rsp;
	wb_req_t                    tmr_req;
	wb_rsp_t                    tmr_rsp;
	logic                       tmr_irq;
	logic [`IRC_FACTOR_NUM-1:0] irc_factor;

	// ----------------------------------------------------------------------
	//  address decoder
	// ----------------------------------------------------------------------

	periph_bus_decoder i_decoder (
		.bus_req_i (bus_req_i),
		.bus_rsp_o (bus_rsp_o),
		.irc_req_o (irc_req),
		.irc_rsp_i (irc_rsp),
		.tmr_req_o (tmr_req),
		.tmr_rsp_i (tmr_rsp)
	);

	// ----------------------------------------------------------------------
	//  interrupt controller
	// ----------------------------------------------------------------------

	// factor 0 timer, factors 1 and 2 external lines
	assign irc_factor = {ext_irq_i, tmr_irq};

	irc_core i_irc (
		.clk       (clk),
		.reset     (reset),
		.factor_i  (irc_factor),
		.irq_o     (irq_o),
		.irq_ack_i (irq_ack_i),
		.bus_req_i (irc_req),
		.bus_rsp_o (irc_rsp)
	);

	// ----------------------------------------------------------------------
	//  timer
	// ----------------------------------------------------------------------

	interval_timer i_timer (
		.clk       (clk),
		.reset     (reset),
		.irq_o     (tmr_irq),
		.bus_req_i (tmr_req),
		.bus_rsp_o (tmr_rsp)
	);

endmodule

// File: timer/interval_timer.sv
/*
 * free-running compare timer with sticky expiry status
 */

`timescale 1ns/1ps

`include "periph_defs.svh"

module interval_timer import periph_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	output logic    irq_o,
	input  wb_req_t bus_req_i,
	output wb_rsp_t bus_rsp_o
);

	localparam int DAT_W = `PERIPH_DAT_W;

	tmr_reg_e         reg_sel;
	logic             bus_first;
	logic             bus_wr;
	logic             compare_wr;
	logic             ack;
	logic [DAT_W-1:0] rd_dat;
	logic [DAT_W-1:0] rsp_dat;

	logic             enable;
	logic [DAT_W-1:0] compare;
	logic [DAT_W-1:0] counter;
	logic             status;
	logic             expire;

	assign reg_sel    = tmr_reg_e'(bus_req_i.adr[1:0]);
	assign bus_first  = bus_req_i.stb & ~ack;
	assign bus_wr     = bus_first & bus_req_i.we;
	assign compare_wr = bus_wr & (reg_sel == TMR_COMPARE);
	assign expire     = enable & (counter == compare);

	// ----------------------------------------------------------------------
	//  counter and status
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack     <= 1'b0;
			enable  <= 1'b0;
			compare <= '0;
			counter <= '0;
			status  <= 1'b0;
		end else begin
			ack <= bus_first;
			if (bus_wr && reg_sel == TMR_CTRL && bus_req_i.sel[0]) begin
				enable <= bus_req_i.dat[0];
			end
			if (compare_wr) begin
				for (int b = 0; b < DAT_W / 8; b++) begin
					if (bus_req_i.sel[b]) begin
						compare[8*b +: 8] <= bus_req_i.dat[8*b +: 8];
					end
				end
			end

			// a new compare value restarts the period
			if (!enable || compare_wr || expire) begin
				counter <= '0;
			end else begin
				counter <= counter + 1'b1;
			end

			// expiry wins over a clear in the same cycle
			if (expire) begin
				status <= 1'b1;
			end else if (bus_wr && reg_sel == TMR_STATUS && bus_req_i.sel[0]
					&& bus_req_i.dat[0]) begin
				status <= 1'b0;
			end
		end
	end

	// read mux
	always_comb begin
		case (reg_sel)
			TMR_CTRL:    rd_dat = DAT_W'(enable);
			TMR_COMPARE: rd_dat = compare;
			TMR_COUNTER: rd_dat = counter;
			TMR_STATUS:  rd_dat = DAT_W'(status);
			default:     rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (bus_first) begin
			rsp_dat <= rd_dat;
		end
	end

	assign bus_rsp_o.dat = rsp_dat;
	assign bus_rsp_o.ack = ack;
	assign irq_o         = status;

	counter_in_range: assert property (
		@(posedge clk) disable iff (reset) enable |-> counter <= compare)
		else $error("timer counter beyond compare");

endmodule

// File: irc/irc_core.sv
/*
 * interrupt controller with per-factor enable and priority,
 * mask level, priority arbitration and acknowledge capture
 */

`timescale 1ns/1ps

`include "periph_defs.svh"

module irc_core import periph_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`IRC_FACTOR_NUM-1:0] factor_i,
	output logic                       irq_o,
	input  logic                       irq_ack_i,
	input  wb_req_t                    bus_req_i,
	output wb_rsp_t                    bus_rsp_o
);

	localparam int DAT_W = `PERIPH_DAT_W;

	irc_reg_e                   reg_sel;
	logic [`IRC_ID_W-1:0]       reg_id;
	logic                       id_ok;
	logic                       bus_first;
	logic                       bus_wr;
	logic                       ack;
	logic [DAT_W-1:0]           rd_dat;
	logic [DAT_W-1:0]           rsp_dat;

	logic                       enable_q;
	logic                       enable_d;
	logic [`IRC_PRI_W-1:0]      mask_q;
	logic [`IRC_PRI_W-1:0]      mask_d;
	logic [`IRC_ID_W-1:0]       req_id;
	logic [`IRC_FACTOR_NUM-1:0] factor_en;
	logic [`IRC_PRI_W-1:0]      factor_pri [`IRC_FACTOR_NUM];
	logic                       irq_q;

	logic [`IRC_FACTOR_NUM-1:0] pending;
	logic                       win_found;
	logic [`IRC_ID_W-1:0]       win_id;
	logic [`IRC_PRI_W-1:0]      win_pri;

	// register decode, factor registers are offset by the factor id
	assign reg_sel   = irc_reg_e'(bus_req_i.adr[`IRC_ID_W +: 4]);
	assign reg_id    = bus_req_i.adr[`IRC_ID_W-1:0];
	assign id_ok     = (reg_id < `IRC_ID_W'(`IRC_FACTOR_NUM));
	assign bus_first = bus_req_i.stb & ~ack;
	assign bus_wr    = bus_first & bus_req_i.we & bus_req_i.sel[0];

	// ----------------------------------------------------------------------
	//  arbitration
	// ----------------------------------------------------------------------

	assign pending = factor_i & factor_en;

	// ascending scan with strict compare, so the lower id wins a tie
	always_comb begin
		win_found = 1'b0;
		win_id    = '0;
		win_pri   = '0;
		for (int i = 0; i < `IRC_FACTOR_NUM; i++) begin
			if (pending[i] && (!win_found || factor_pri[i] > win_pri)) begin
				win_found = 1'b1;
				win_id    = `IRC_ID_W'(i);
				win_pri   = factor_pri[i];
			end
		end
	end

	// next enable and mask, acknowledge overrides a mask write
	always_comb begin
		enable_d = enable_q;
		mask_d   = mask_q;
		if (bus_wr && reg_sel == IRC_ENABLE) begin
			enable_d = bus_req_i.dat[0];
		end
		if (bus_wr && reg_sel == IRC_MASK) begin
			mask_d = bus_req_i.dat[`IRC_PRI_W-1:0];
		end
		if (irq_ack_i && win_found) begin
			mask_d = win_pri;
		end
	end

	// ----------------------------------------------------------------------
	//  registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack       <= 1'b0;
			enable_q  <= 1'b0;
			mask_q    <= '0;
			req_id    <= '0;
			factor_en <= '0;
			irq_q     <= 1'b0;
			for (int i = 0; i < `IRC_FACTOR_NUM; i++) begin
				factor_pri[i] <= '0;
			end
		end else begin
			ack      <= bus_first;
			enable_q <= enable_d;
			mask_q   <= mask_d;
			irq_q    <= enable_d & win_found & (win_pri > mask_d);
			if (irq_ack_i && win_found) begin
				req_id <= win_id;
			end
			if (bus_wr && id_ok && reg_sel == IRC_FACTOR_EN) begin
				factor_en[reg_id] <= bus_req_i.dat[0];
			end
			if (bus_wr && id_ok && reg_sel == IRC_FACTOR_PRI) begin
				factor_pri[reg_id] <= bus_req_i.dat[`IRC_PRI_W-1:0];
			end
		end
	end

	// read mux
	always_comb begin
		case (reg_sel)
			IRC_ENABLE:     rd_dat = DAT_W'(enable_q);
			IRC_MASK:       rd_dat = DAT_W'(mask_q);
			IRC_REQ_ID:     rd_dat = DAT_W'(req_id);
			IRC_FACTOR_EN:  rd_dat = id_ok ? DAT_W'(factor_en[reg_id]) : '0;
			IRC_FACTOR_PRI: rd_dat = id_ok ? DAT_W'(factor_pri[reg_id]) : '0;
			default:        rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (bus_first) begin
			rsp_dat <= rd_dat;
		end
	end

	assign bus_rsp_o.dat = rsp_dat;
	assign bus_rsp_o.ack = ack;
	assign irq_o         = irq_q;

	irq_needs_enable: assert property (@(posedge clk) disable iff (reset) irq_o |-> enable_q)
		else $error("irq high with global enable off");

	ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("irc ack longer than one cycle");

endmodule

// File: src/periph_bus_decoder.sv
/*
 * address decoder for the peripheral bus, stb gating per region
 * and response multiplexing with a zero answer for unmapped regions
 */

`timescale 1ns/1ps

`include "periph_defs.svh"

module periph_bus_decoder import periph_pkg::*; (
	input  wb_req_t bus_req_i,
	output wb_rsp_t bus_rsp_o,
	output wb_req_t irc_req_o,
	input  wb_rsp_t irc_rsp_i,
	output wb_req_t tmr_req_o,
	input  wb_rsp_t tmr_rsp_i
);

	logic [7:0] region;
	logic       irc_hit;
	logic       tmr_hit;

	// top byte of the byte address
	assign region  = bus_req_i.adr[29:22];
	assign irc_hit = (region == `REGION_IRC);
	assign tmr_hit = (region == `REGION_TIMER);

	// ----------------------------------------------------------------------
	//  request forwarding
	// ----------------------------------------------------------------------

	always_comb begin
		irc_req_o     = bus_req_i;
		irc_req_o.stb = bus_req_i.stb & irc_hit;
		tmr_req_o     = bus_req_i;
		tmr_req_o.stb = bus_req_i.stb & tmr_hit;
	end

	// ----------------------------------------------------------------------
	//  response select
	// ----------------------------------------------------------------------

	always_comb begin
		if (irc_req_o.stb) begin
			bus_rsp_o = irc_rsp_i;
		end else if (tmr_req_o.stb) begin
			bus_rsp_o = tmr_rsp_i;
		end else begin
			// unmapped, answered in the same cycle
			bus_rsp_o.dat = '0;
			bus_rsp_o.ack = bus_req_i.stb;
		end
	end

	// at most one slave sees the strobe
	always_comb begin
		assert ($onehot0({irc_req_o.stb, tmr_req_o.stb}))
			else $error("decoder selected more than one slave");
	end

endmodule

// File: common/periph_pkg.sv
/*
 * peripheral bus request/response structs and register select enums
 */

`include "periph_defs.svh"

package periph_pkg;

	// single-beat bus request, adr is the word address (byte address bits 31:2)
	typedef struct packed {
		logic [29:0]              adr;
		logic [`PERIPH_DAT_W-1:0] dat;
		logic                     we;
		logic [3:0]               sel;
		logic                     stb;
	} wb_req_t;

	// bus response
	typedef struct packed {
		logic [`PERIPH_DAT_W-1:0] dat;
		logic                     ack;
	} wb_rsp_t;

	// irc register group, word address = {group, factor id}
	typedef enum logic [3:0] {
		IRC_ENABLE     = 4'h0,
		IRC_MASK       = 4'h1,
		IRC_REQ_ID     = 4'h2,
		IRC_FACTOR_EN  = 4'h4,
		IRC_FACTOR_PRI = 4'h5
	} irc_reg_e;

	// timer register word address
	typedef enum logic [1:0] {
		TMR_CTRL    = 2'd0,
		TMR_COMPARE = 2'd1,
		TMR_COUNTER = 2'd2,
		TMR_STATUS  = 2'd3
	} tmr_reg_e;

endpackage

// File: common/periph_defs.svh
/*
 * bus data width, region codes and interrupt controller sizes
 */

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// bus data width
`define PERIPH_DAT_W     32

// top address byte of each slave region
`define REGION_IRC       8'hF0
`define REGION_TIMER     8'hF1

// interrupt controller sizing
`define IRC_FACTOR_NUM   3
`define IRC_ID_W         2
`define IRC_PRI_W        2

`endif
